//--- Makefile
# Verilator flow for the timed pin controller

VERILATOR ?= verilator
TB_TOP    ?= pin_io_tb
RTL_TOP   ?= pin_io_top
FILELIST  ?= pin_io_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
PASS_MSG  ?= Everything OK

RTL_SRCS ?= hdl/pin_io_pkg.sv hdl/pin_timebase.sv hdl/pin_channel.sv \
            hdl/pin_merge.sv hdl/pin_io_top.sv
TB_SRCS  ?= sim/pin_io_sva.sv sim/pin_io_tb.sv
GOLDEN   ?= sim/pin_io_golden.txt

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) --binary --timing --assert --timescale $(TIMESCALE) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP) $(GOLDEN)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/pin_channel.sv
module pin_channel #(
    parameter int position = 1
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enable,
    input  logic [pin_io_pkg::addr_w-1:0]   addr,
    input  logic                            data_wr,
    input  logic                            data_rd,
    input  logic [pin_io_pkg::wdata_w-1:0]  data_in,
    input  logic [pin_io_pkg::time_w-1:0]   current_time,
    input  logic                            clock_running,
    input  logic                            output_sample,
    input  logic [pin_io_pkg::page_w-1:0]   channel_select,
    input  logic                            pin_in,
    output logic [pin_io_pkg::rdata_w-1:0]  rd_word,
    output logic [pin_io_pkg::sample_w-1:0] sample_word,
    output logic                            pin_out,
    output logic                            pin_oe
);
    import pin_io_pkg::*;

    localparam int pos_w = sample_w - rdata_w - 1;  // page field inside the sample word
    localparam logic [page_w-1:0] page_id   = page_w'(position);
    localparam logic [pos_w-1:0]  pos_field = pos_w'(position);

    typedef enum logic [3:0] {
        st_idle         = 4'b0001,
        st_const        = 4'b0010,
        st_input_stream = 4'b0100,
        st_enable_out   = 4'b1000
    } state_t;

    state_t state;
    state_t next_state;

    logic               hit;
    logic [page_w-1:0]  offset;
    logic [wdata_w-1:0] command;
    logic [wdata_w-1:0] nco_inc;
    logic [time_w-1:0]  end_time;
    logic [wdata_w-1:0] sample_rate;
    logic [time_w-1:0]  rec_start_time;
    logic [wdata_w-1:0] rate_cnt;
    logic [rdata_w-1:0] sample_cnt;
    logic               sample_reg;
    logic [wdata_w-1:0] phase_acc;
    logic               timed_end;
    logic               start_condition;

    // control strobes from the job FSM
    logic cmd_clear;
    logic rec_clear;
    logic smp_clear;
    logic smp_reload;
    logic smp_dec;
    logic smp_take;
    logic acc_zero;
    logic acc_ones;
    logic acc_add;

    assign hit    = enable && (addr[addr_w-1:page_w] == page_id);
    assign offset = addr[page_w-1:0];

    assign timed_end       = (end_time != '0) && (current_time > end_time);
    assign start_condition = current_time >= rec_start_time;

    always_ff @(posedge clk) begin
        if (reset) begin
            command        <= '0;
            nco_inc        <= '0;
            end_time       <= '0;
            sample_rate    <= '0;
            rec_start_time <= '0;
        end else begin
            // the FSM clearing the command beats a write in the same cycle, hence the hold rule
            if (cmd_clear)
                command <= '0;
            else if (hit && data_wr && (offset == ADDR_LOCAL_CMD))
                command <= data_in;

            if (rec_clear)
                rec_start_time <= '0;
            else if (hit && data_wr && (offset == ADDR_REC_START_TIME))
                rec_start_time <= data_in;

            if (hit && data_wr) begin
                case (offset)
                    ADDR_NCO_INC:     nco_inc     <= data_in;
                    ADDR_END_TIME:    end_time    <= data_in;
                    ADDR_SAMPLE_RATE: sample_rate <= data_in;
                    default:          ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        cmd_clear  = 1'b0;
        rec_clear  = 1'b0;
        smp_clear  = 1'b0;
        smp_reload = 1'b0;
        smp_dec    = 1'b0;
        smp_take   = 1'b0;
        acc_zero   = 1'b0;
        acc_ones   = 1'b0;
        acc_add    = 1'b0;

        case (state)
            st_idle: begin
                smp_reload = 1'b1;  // rate counter waits preloaded for the next stream
                if (clock_running) begin
                    if (rec_start_time != '0) begin
                        cmd_clear  = 1'b1;  // a record start time alone starts streaming
                        next_state = st_input_stream;
                    end else begin
                        case (command)
                            CMD_INPUT_STREAM: begin
                                cmd_clear  = 1'b1;
                                next_state = st_input_stream;
                            end
                            CMD_SQUARE_WAVE: begin
                                cmd_clear  = 1'b1;
                                next_state = st_enable_out;
                            end
                            CMD_CONST: begin
                                cmd_clear  = 1'b1;
                                acc_ones   = 1'b1;
                                next_state = st_const;
                            end
                            CMD_RESET: begin
                                cmd_clear = 1'b1;
                                acc_zero  = 1'b1;
                            end
                            default: ;
                        endcase
                    end
                end
            end

            st_const: begin
                acc_ones = 1'b1;  // all ones keeps the MSB and so the pin high
                if ((command == CMD_RESET) || timed_end) begin
                    cmd_clear  = 1'b1;
                    acc_zero   = 1'b1;
                    next_state = st_idle;
                end
            end

            st_enable_out: begin
                acc_add = 1'b1;
                if ((command == CMD_RESET) || timed_end) begin
                    cmd_clear  = 1'b1;
                    acc_zero   = 1'b1;
                    next_state = st_idle;
                end
            end

            st_input_stream: begin
                if (start_condition) begin
                    if (rate_cnt == '0)
                        smp_take = 1'b1;
                    else
                        smp_dec = 1'b1;
                end
                if ((command == CMD_RESET) || timed_end) begin
                    cmd_clear  = 1'b1;
                    rec_clear  = 1'b1;
                    smp_clear  = 1'b1;
                    next_state = st_idle;
                end
            end

            default: next_state = st_idle;
        endcase
    end

    // one sample every sample_rate plus one cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            rate_cnt   <= '0;
            sample_cnt <= '0;
            sample_reg <= 1'b0;
        end else if (smp_clear) begin
            rate_cnt   <= '0;
            sample_cnt <= '0;
            sample_reg <= 1'b0;
        end else if (clock_running) begin
            if (smp_reload || smp_take)
                rate_cnt <= sample_rate;
            else if (smp_dec)
                rate_cnt <= rate_cnt - 1'b1;

            if (smp_take) begin
                sample_reg <= pin_in;
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    // output frequency is about f(clk) * nco_inc / 2^32
    always_ff @(posedge clk) begin
        if (reset)
            phase_acc <= '0;
        else if (acc_zero)
            phase_acc <= '0;
        else if (acc_ones)
            phase_acc <= '1;
        else if (acc_add)
            phase_acc <= phase_acc + nco_inc;
    end

    assign pin_out = phase_acc[wdata_w-1];
    assign pin_oe  = (state == st_const) || (state == st_enable_out);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_word     <= '0;
            sample_word <= '0;
        end else begin
            if (hit && data_rd) begin
                case (offset)
                    ADDR_SAMPLE_REG: rd_word <= {{(rdata_w-1){1'b0}}, sample_reg};
                    ADDR_SAMPLE_CNT: rd_word <= sample_cnt;
                    ADDR_STATUS_REG: rd_word <= rdata_w'(position);
                    default:         rd_word <= '0;
                endcase
            end else begin
                rd_word <= '0;
            end

            if (output_sample && (channel_select == page_id))
                sample_word <= {sample_cnt, pos_field, sample_reg};
            else
                sample_word <= '0;  // only the selected channel contributes
        end
    end

endmodule

//--- hdl/pin_io_pkg.sv
package pin_io_pkg;

    localparam int addr_w   = 16;  // host bus address, page in the upper byte
    localparam int page_w   = 8;   // width of the page number and of the register offset
    localparam int wdata_w  = 32;
    localparam int rdata_w  = 16;
    localparam int time_w   = 32;  // current_time, end time and record start time
    localparam int sample_w = 32;  // count, page and pin level packed together

    // channel register offsets in the low address byte
    localparam logic [page_w-1:0] ADDR_NCO_INC        = 8'd1;
    localparam logic [page_w-1:0] ADDR_END_TIME       = 8'd2;
    localparam logic [page_w-1:0] ADDR_LOCAL_CMD      = 8'd3;
    localparam logic [page_w-1:0] ADDR_SAMPLE_RATE    = 8'd4;
    localparam logic [page_w-1:0] ADDR_SAMPLE_REG     = 8'd5;
    localparam logic [page_w-1:0] ADDR_REC_START_TIME = 8'd6;
    localparam logic [page_w-1:0] ADDR_SAMPLE_CNT     = 8'd7;
    localparam logic [page_w-1:0] ADDR_STATUS_REG     = 8'd8;

    // timebase offsets on page 0
    localparam logic [page_w-1:0] ADDR_GLOBAL_CMD = 8'd0;
    localparam logic [page_w-1:0] ADDR_TIME_LO    = 8'd1;
    localparam logic [page_w-1:0] ADDR_TIME_HI    = 8'd2;

    localparam logic [wdata_w-1:0] CMD_CONST        = 32'd2;
    localparam logic [wdata_w-1:0] CMD_SQUARE_WAVE  = 32'd3;
    localparam logic [wdata_w-1:0] CMD_INPUT_STREAM = 32'd4;
    localparam logic [wdata_w-1:0] CMD_RESET        = 32'd5;

    localparam logic [wdata_w-1:0] GCMD_START = 32'd1;
    localparam logic [wdata_w-1:0] GCMD_STOP  = 32'd2;
    localparam logic [wdata_w-1:0] GCMD_CLEAR = 32'd3;

endpackage

//--- hdl/pin_io_top.sv
module pin_io_top #(
    parameter int num_channels = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enable,
    input  logic [pin_io_pkg::addr_w-1:0]   addr,
    input  logic                            data_wr,
    input  logic                            data_rd,
    input  logic [pin_io_pkg::wdata_w-1:0]  data_in,
    input  logic                            output_sample,
    input  logic [pin_io_pkg::page_w-1:0]   channel_select,
    input  logic [num_channels-1:0]         pin_in,
    output logic [pin_io_pkg::rdata_w-1:0]  rd_data,
    output logic [pin_io_pkg::sample_w-1:0] sample_data,
    output logic [pin_io_pkg::time_w-1:0]   current_time,
    output logic                            clock_running,
    output logic [num_channels-1:0]         pin_out,
    output logic [num_channels-1:0]         pin_oe
);
    import pin_io_pkg::*;

    logic [rdata_w-1:0]  rd_words     [num_channels+1];  // slot 0 is the timebase
    logic [sample_w-1:0] sample_words [num_channels];

    pin_timebase u_timebase (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .addr          (addr),
        .data_wr       (data_wr),
        .data_rd       (data_rd),
        .data_in       (data_in),
        .current_time  (current_time),
        .clock_running (clock_running),
        .rd_word       (rd_words[0])
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_channel
        pin_channel #(
            .position (i + 1)
        ) u_channel (
            .clk            (clk),
            .reset          (reset),
            .enable         (enable),
            .addr           (addr),
            .data_wr        (data_wr),
            .data_rd        (data_rd),
            .data_in        (data_in),
            .current_time   (current_time),
            .clock_running  (clock_running),
            .output_sample  (output_sample),
            .channel_select (channel_select),
            .pin_in         (pin_in[i]),
            .rd_word        (rd_words[i+1]),
            .sample_word    (sample_words[i]),
            .pin_out        (pin_out[i]),
            .pin_oe         (pin_oe[i])
        );
    end

    pin_merge #(
        .payload_t   (logic [rdata_w-1:0]),
        .num_sources (num_channels + 1)
    ) u_rd_merge (
        .clk    (clk),
        .reset  (reset),
        .words  (rd_words),
        .merged (rd_data)
    );

    pin_merge #(
        .payload_t   (logic [sample_w-1:0]),
        .num_sources (num_channels)
    ) u_sample_merge (
        .clk    (clk),
        .reset  (reset),
        .words  (sample_words),
        .merged (sample_data)
    );

endmodule

//--- hdl/pin_merge.sv
module pin_merge #(
    parameter type payload_t = logic [15:0],
    parameter int  num_sources = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  payload_t words [num_sources],
    output payload_t merged
);

    payload_t any_word;

    // sources that are not addressed drive zero, so OR acts as the mux
    always_comb begin
        any_word = '0;
        for (int i = 0; i < num_sources; i++) begin
            any_word = any_word | words[i];
        end
    end

    // registered so that no path from the channels reaches the pads
    always_ff @(posedge clk) begin
        if (reset)
            merged <= '0;
        else
            merged <= any_word;
    end

endmodule

//--- hdl/pin_timebase.sv
module pin_timebase (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [pin_io_pkg::addr_w-1:0]  addr,
    input  logic                           data_wr,
    input  logic                           data_rd,
    input  logic [pin_io_pkg::wdata_w-1:0] data_in,
    output logic [pin_io_pkg::time_w-1:0]  current_time,
    output logic                           clock_running,
    output logic [pin_io_pkg::rdata_w-1:0] rd_word
);
    import pin_io_pkg::*;

    logic               hit;
    logic [page_w-1:0]  offset;
    logic [wdata_w-1:0] gcmd;

    assign hit    = enable && (addr[addr_w-1:page_w] == '0);  // page 0 only
    assign offset = addr[page_w-1:0];

    // the global command word exists only in the cycle it is written
    assign gcmd = (hit && data_wr && (offset == ADDR_GLOBAL_CMD)) ? data_in : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            clock_running <= 1'b0;
            current_time  <= '0;
        end else begin
            if (gcmd == GCMD_START)
                clock_running <= 1'b1;
            else if (gcmd == GCMD_STOP)
                clock_running <= 1'b0;

            if (gcmd == GCMD_CLEAR)
                current_time <= '0;  // clear wins over counting in the same cycle
            else if (clock_running)
                current_time <= current_time + 1'b1;
        end
    end

    // time readback, one half of the counter per offset
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_word <= '0;
        end else if (hit && data_rd) begin
            case (offset)
                ADDR_TIME_LO: rd_word <= current_time[rdata_w-1:0];
                ADDR_TIME_HI: rd_word <= current_time[time_w-1:rdata_w];
                default:      rd_word <= '0;
            endcase
        end else begin
            rd_word <= '0;  // zero unless this page was read
        end
    end

endmodule

//--- pin_io_top.f
hdl/pin_io_pkg.sv
hdl/pin_timebase.sv
hdl/pin_channel.sv
hdl/pin_merge.sv
hdl/pin_io_top.sv
sim/pin_io_sva.sv
sim/pin_io_tb.sv

//--- sim/pin_io_golden.txt
# op and hex fields: W addr data | R addr expected tol | E addr (equal to last R)
# S page expected tol_on_count | P ch oe out | I ch level | N cycles | Q ch window expected tol
R 0108 1 0
R 0208 2 0
R 0308 3 0
R 0408 4 0
R 0109 0 0
R 0003 0 0
W 0204 7
R 0108 1 0
W 0000 1
N 14
R 0001 1e a
W 0000 2
R 0001 30 20
N 8
E 0001
W 0000 3
R 0001 0 0
R 0002 0 0
W 0303 2
N 4
P 3 0 0
W 0303 5
W 0102 60
W 0000 1
W 0103 2
P 1 1 1
N 64
P 1 0 0
P 3 0 0
W 0201 40000000
W 0203 3
Q 2 28 14 1
W 0203 5
P 2 0 0
Q 2 14 0 0
W 0000 2
W 0000 3
W 0404 3
W 0402 80
I 4 1
W 0406 1
W 0000 1
N 28
R 0407 a 2
R 0405 1 0
S 4 000d0009 2
N 64
R 0407 0 0
R 0405 0 0
S 4 00000008 0
W 0402 0
W 0403 4
N 14
R 0407 5 2

//--- sim/pin_io_sva.sv
module pin_io_sva #(
    parameter int num_channels = 4
) (
    input logic                            clk,
    input logic                            reset,
    input logic                            enable,
    input logic                            data_rd,
    input logic                            output_sample,
    input logic [pin_io_pkg::rdata_w-1:0]  rd_data,
    input logic [pin_io_pkg::sample_w-1:0] sample_data,
    input logic [num_channels-1:0]         pin_out,
    input logic [num_channels-1:0]         pin_oe
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // failed assertions so far, read by the testbench

    // channel register plus merge register put the read word two edges late
    rd_after_read: assert property (@(posedge clk) disable iff (reset)
        (rd_data != '0) |-> $past(enable && data_rd, 2))
        else begin
            fail_count = fail_count + 1;
            $error("rd_data is nonzero without a read edge two cycles earlier");
        end

    sample_after_request: assert property (@(posedge clk) disable iff (reset)
        (sample_data != '0) |-> $past(output_sample, 2))
        else begin
            fail_count = fail_count + 1;
            $error("sample_data is nonzero without an output_sample edge two cycles earlier");
        end

    // the accumulator is zeroed whenever a driving job leaves its state
    out_needs_oe: assert property (@(posedge clk) disable iff (reset)
        (pin_out & ~pin_oe) == '0)
        else begin
            fail_count = fail_count + 1;
            $error("pin_out is high on a channel whose pin_oe is low");
        end

    oe_low_in_reset: assert property (@(posedge clk) reset |=> (pin_oe == '0))
        else begin
            fail_count = fail_count + 1;
            $error("pin_oe is high while reset is asserted");
        end

endmodule

bind pin_io_top pin_io_sva #(
    .num_channels (num_channels)
) u_sva (
    .clk           (clk),
    .reset         (reset),
    .enable        (enable),
    .data_rd       (data_rd),
    .output_sample (output_sample),
    .rd_data       (rd_data),
    .sample_data   (sample_data),
    .pin_out       (pin_out),
    .pin_oe        (pin_oe)
);

//--- sim/pin_io_tb.sv
module pin_io_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import pin_io_pkg::*;

    localparam int num_channels = 4;
    localparam int run_timeout  = 8;  // cycles for clock_running to follow a global command

    logic                    clk;
    logic                    reset;
    logic                    enable;
    logic [addr_w-1:0]       addr;
    logic                    data_wr;
    logic                    data_rd;
    logic [wdata_w-1:0]      data_in;
    logic                    output_sample;
    logic [page_w-1:0]       channel_select;
    logic [num_channels-1:0] pin_in;
    logic [rdata_w-1:0]      rd_data;
    logic [sample_w-1:0]     sample_data;
    logic [time_w-1:0]       current_time;
    logic                    clock_running;
    logic [num_channels-1:0] pin_out;
    logic [num_channels-1:0] pin_oe;

    integer             seed = 51;
    logic [rdata_w-1:0] last_read;  // kept for the E op
    logic               global_wr;
    logic               run_model;
    logic [time_w-1:0]  time_model;

    pin_io_top #(
        .num_channels (num_channels)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .addr           (addr),
        .data_wr        (data_wr),
        .data_rd        (data_rd),
        .data_in        (data_in),
        .output_sample  (output_sample),
        .channel_select (channel_select),
        .pin_in         (pin_in),
        .rd_data        (rd_data),
        .sample_data    (sample_data),
        .current_time   (current_time),
        .clock_running  (clock_running),
        .pin_out        (pin_out),
        .pin_oe         (pin_oe)
    );

    always #50 clk = ~clk;

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input logic [31:0] tol, input string what);
        logic [31:0] diff;
        diff = (got > expected) ? got - expected : expected - got;
        if ($isunknown(got) || (diff > tol)) begin
            $display("ERR %0t: %s, got 0x%0h, expected 0x%0h within 0x%0h",
                     $time, what, got, expected, tol);
            stop_on_failure();
        end
    endtask

    task automatic need_fields(input int code, input int count);
        if (code != count) begin
            $display("a line of the golden file has missing or unreadable fields");
            stop_on_failure();
        end
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            @(posedge clk);
    endtask

    task automatic wait_running(input logic level);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while ((clock_running !== level) && (cyc < run_timeout)) begin
            @(negedge clk);
            cyc++;
        end
        if (clock_running !== level) begin
            $display("timeout: clock_running did not follow the global command");
            stop_on_failure();
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        enable  <= 1'b1;
        data_wr <= 1'b1;
        addr    <= a[addr_w-1:0];
        data_in <= d;
        @(posedge clk);  // write edge
        enable  <= 1'b0;
        data_wr <= 1'b0;
        @(posedge clk);  // idle cycle the channels need between commands
        if (a[addr_w-1:0] == {8'h00, ADDR_GLOBAL_CMD}) begin
            if (d == GCMD_START)
                wait_running(1'b1);
            else if (d == GCMD_STOP)
                wait_running(1'b0);
        end
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [rdata_w-1:0] value);
        @(posedge clk);
        enable  <= 1'b1;
        data_rd <= 1'b1;
        addr    <= a[addr_w-1:0];
        @(posedge clk);  // read edge, the source registers its word here
        enable  <= 1'b0;
        data_rd <= 1'b0;
        @(posedge clk);  // merge register
        @(negedge clk);
        value = rd_data;
    endtask

    task automatic request_sample(input logic [31:0] page, output logic [sample_w-1:0] value);
        @(posedge clk);
        output_sample  <= 1'b1;
        channel_select <= page[page_w-1:0];
        @(posedge clk);
        output_sample  <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        value = sample_data;
    endtask

    task automatic count_toggles(input int idx, input int window, output int toggles);
        logic prev;
        toggles = 0;
        @(negedge clk);
        prev = pin_out[idx];
        for (int i = 0; i < window; i++) begin
            @(negedge clk);
            if (pin_out[idx] !== prev)
                toggles++;
            prev = pin_out[idx];
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while ((ch != 10) && (ch != -1))  // 10 is the newline
            ch = $fgetc(fd);
    endtask

    assign global_wr = enable && data_wr && (addr == {8'h00, ADDR_GLOBAL_CMD});

    // expected timebase, counting cycles from the global commands put on the bus
    always @(posedge clk) begin
        if (reset) begin
            run_model  <= 1'b0;
            time_model <= '0;
        end else begin
            if (global_wr && (data_in == GCMD_START))
                run_model <= 1'b1;
            else if (global_wr && (data_in == GCMD_STOP))
                run_model <= 1'b0;

            if (global_wr && (data_in == GCMD_CLEAR))
                time_model <= '0;
            else if (run_model)
                time_model <= time_model + 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            check_value(current_time, time_model, 0, "current_time");
            check_value({31'b0, clock_running}, {31'b0, run_model}, 0, "clock_running");
        end
        if (u_dut.u_sva.fail_count != 0) begin
            $display("an assertion of the bound checker failed");
            stop_on_failure();
        end
    end

    initial begin
        int                  fd;
        int                  code;
        int                  gap;
        int                  idx;
        int                  toggles;
        logic [7:0]          op;
        logic [31:0]         f1;
        logic [31:0]         f2;
        logic [31:0]         f3;
        logic [31:0]         f4;
        logic [rdata_w-1:0]  rd_val;
        logic [sample_w-1:0] smp_val;

        clk            = 1'b0;
        reset          = 1'b1;
        enable         = 1'b0;
        addr           = '0;
        data_wr        = 1'b0;
        data_rd        = 1'b0;
        data_in        = '0;
        output_sample  = 1'b0;
        channel_select = '0;
        pin_in         = '0;
        last_read      = '0;

        for (int i = 0; i < 16; i++)
            @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("sim/pin_io_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file sim/pin_io_golden.txt");
            stop_on_failure();
        end

        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            case (op)
                "#": skip_line(fd);
                "W": begin
                    code = $fscanf(fd, "%h %h", f1, f2);
                    need_fields(code, 2);
                    bus_write(f1, f2);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    need_fields(code, 3);
                    bus_read(f1, rd_val);
                    check_value({16'b0, rd_val}, f2, f3,
                                $sformatf("read of 0x%04h", f1[15:0]));
                    last_read = rd_val;
                end
                "E": begin
                    code = $fscanf(fd, "%h", f1);
                    need_fields(code, 1);
                    bus_read(f1, rd_val);
                    check_value({16'b0, rd_val}, {16'b0, last_read}, 0,
                                $sformatf("repeated read of 0x%04h", f1[15:0]));
                end
                "S": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    need_fields(code, 3);
                    request_sample(f1, smp_val);
                    check_value({16'b0, smp_val[15:0]}, {16'b0, f2[15:0]}, 0,
                                $sformatf("page and level of the sample word of page %0d", f1));
                    check_value({16'b0, smp_val[31:16]}, {16'b0, f2[31:16]}, f3,
                                $sformatf("count in the sample word of page %0d", f1));
                end
                "P": begin
                    code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                    need_fields(code, 3);
                    idx = int'(f1) - 1;
                    @(negedge clk);
                    check_value({31'b0, pin_oe[idx]}, f2, 0,
                                $sformatf("pin_oe of channel %0d", f1));
                    check_value({31'b0, pin_out[idx]}, f3, 0,
                                $sformatf("pin_out of channel %0d", f1));
                end
                "I": begin
                    code = $fscanf(fd, "%h %h", f1, f2);
                    need_fields(code, 2);
                    idx = int'(f1) - 1;
                    @(posedge clk);
                    pin_in[idx] <= f2[0];
                end
                "N": begin
                    code = $fscanf(fd, "%h", f1);
                    need_fields(code, 1);
                    wait_cycles(int'(f1));
                end
                "Q": begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    need_fields(code, 4);
                    count_toggles(int'(f1) - 1, int'(f2), toggles);
                    check_value(32'(toggles), f3, f4,
                                $sformatf("pin_out toggles of channel %0d", f1));
                end
                default: begin
                    $display("the golden file holds an unknown operation letter");
                    stop_on_failure();
                end
            endcase
            if (op != "#") begin
                gap = 1 + (($random(seed) & 32'h7fff_ffff) % 3);  // idle gap of 1 to 3 cycles
                wait_cycles(gap);
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);

        if (u_dut.u_sva.fail_count != 0) begin
            $display("an assertion of the bound checker failed");
            stop_on_failure();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
